// ==== compile.f ====
+incdir+common
common/rv_fe_pkg.sv
common/rv_fe_intf.sv
hw/btb.sv
hw/pc_sel_arbiter.sv
stage_pc/stage_pc.sv
hw/fe_top.sv
dv/fe_sva.sv
dv/fe_tb.sv

// ==== Bender.yml ====
package:
  name: rv_fe

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv_fe_pkg.sv
      - common/rv_fe_intf.sv
      - hw/btb.sv
      - hw/pc_sel_arbiter.sv
      - stage_pc/stage_pc.sv
      - hw/fe_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/fe_sva.sv
      - dv/fe_tb.sv

// ==== dv/fe_tb.sv ====
`timescale 1ns/1ns

`include "rv_fe_settings.svh"

module fe_tb import rv_fe_pkg::*; ();

  // Test lengths in cycles
  localparam int SEQ_LEN      = 8;
  localparam int STALL_ROUNDS = 4;
  localparam int STALL_LEN    = STALL_ROUNDS * 10;
  localparam int REDIR_ROUNDS = 3;
  localparam int REDIR_LEN    = REDIR_ROUNDS * 2;
  localparam int PRED_LEN     = 16;
  localparam int IMEM_LEN     = 16;
  localparam int TEST_LEN     = 3 + SEQ_LEN + STALL_LEN + REDIR_LEN + PRED_LEN + IMEM_LEN;
  localparam int RUN_LIMIT    = 2 * TEST_LEN + 100;

  // Trained branch sits away from the random targets
  localparam pc_t BTB_REGION = 32'h0000_2000;

  logic clk;
  logic rst_n;
  logic redirect_valid_i;
  pc_t  redirect_tgt_i;
  logic static_pred_valid_i;
  pc_t  static_pred_tgt_i;
  logic btb_upd_valid_i;
  pc_t  btb_upd_pc_i;
  pc_t  btb_upd_tgt_i;
  logic stall_i;
  logic imem_stall_i;
  logic fetch_valid_o;
  pc_t  fetch_pc_o;
  pc_t  fetch_pc_next_o;
  logic fetch_btb_hit_o;
  pc_t  fetch_btb_tgt_o;
  logic fetch_redir_pending_o;

  // PC expected in the next valid handoff
  pc_t  exp_pc;
  int   cycle_count;
  logic [31:0] lfsr_state;

  // Snapshot for stall checks
  logic held_valid;
  pc_t  held_pc;
  pc_t  held_pc_next;
  logic held_btb_hit;
  pc_t  held_btb_tgt;
  logic held_redir;

  fe_top fe_top_inst (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .redirect_valid_i      (redirect_valid_i),
    .redirect_tgt_i        (redirect_tgt_i),
    .static_pred_valid_i   (static_pred_valid_i),
    .static_pred_tgt_i     (static_pred_tgt_i),
    .btb_upd_valid_i       (btb_upd_valid_i),
    .btb_upd_pc_i          (btb_upd_pc_i),
    .btb_upd_tgt_i         (btb_upd_tgt_i),
    .stall_i               (stall_i),
    .imem_stall_i          (imem_stall_i),
    .fetch_valid_o         (fetch_valid_o),
    .fetch_pc_o            (fetch_pc_o),
    .fetch_pc_next_o       (fetch_pc_next_o),
    .fetch_btb_hit_o       (fetch_btb_hit_o),
    .fetch_btb_tgt_o       (fetch_btb_tgt_o),
    .fetch_redir_pending_o (fetch_redir_pending_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Run limit and assertion watch
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (fe_top_inst.fe_sva_inst.fail_count != 0) begin
        abort_run("An assertion on the fetch handoff failed");
      end
      if (cycle_count >= RUN_LIMIT) begin
        abort_run($sformatf("Run did not finish within %0d cycles", RUN_LIMIT));
      end
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out_bit;
  endfunction

  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      value = {value[30:0], lfsr_step()};
    end
    return value;
  endfunction

  // Word-aligned target in the upper region
  function automatic pc_t random_target();
    return pc_t'(32'h4000_0000 | (random_bits(20) << 2));
  endfunction

  // Inputs change 1 ns after the edge, outputs are settled by then
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_inputs();
    redirect_valid_i    = 1'b0;
    redirect_tgt_i      = '0;
    static_pred_valid_i = 1'b0;
    static_pred_tgt_i   = '0;
    btb_upd_valid_i     = 1'b0;
    btb_upd_pc_i        = '0;
    btb_upd_tgt_i       = '0;
  endtask

  task automatic expect_sequential();
    check_bit("fetch_valid_o", fetch_valid_o, 1'b1);
    check_pc("fetch_pc_o", fetch_pc_o, exp_pc);
    check_pc("fetch_pc_next_o", fetch_pc_next_o, exp_pc + 32'd4);
    check_bit("fetch_btb_hit_o", fetch_btb_hit_o, 1'b0);
    check_bit("fetch_redir_pending_o", fetch_redir_pending_o, 1'b0);
    exp_pc = exp_pc + 32'd4;
  endtask

  // Handoff that announces a redirect or late prediction
  task automatic expect_redirect(input pc_t tgt);
    check_bit("fetch_valid_o", fetch_valid_o, 1'b1);
    check_pc("fetch_pc_o", fetch_pc_o, exp_pc);
    check_pc("fetch_pc_next_o", fetch_pc_next_o, tgt);
    check_bit("fetch_btb_hit_o", fetch_btb_hit_o, 1'b0);
    check_bit("fetch_redir_pending_o", fetch_redir_pending_o, 1'b1);
    exp_pc = tgt;
  endtask

  task automatic save_outputs();
    held_valid   = fetch_valid_o;
    held_pc      = fetch_pc_o;
    held_pc_next = fetch_pc_next_o;
    held_btb_hit = fetch_btb_hit_o;
    held_btb_tgt = fetch_btb_tgt_o;
    held_redir   = fetch_redir_pending_o;
  endtask

  task automatic check_held();
    check_bit("fetch_valid_o", fetch_valid_o, held_valid);
    check_pc("fetch_pc_o", fetch_pc_o, held_pc);
    check_pc("fetch_pc_next_o", fetch_pc_next_o, held_pc_next);
    check_bit("fetch_btb_hit_o", fetch_btb_hit_o, held_btb_hit);
    check_pc("fetch_btb_tgt_o", fetch_btb_tgt_o, held_btb_tgt);
    check_bit("fetch_redir_pending_o", fetch_redir_pending_o, held_redir);
  endtask

  task automatic sequential_flow();
    check_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    check_bit("fetch_redir_pending_o", fetch_redir_pending_o, 1'b0);
    check_bit("fetch_btb_hit_o", fetch_btb_hit_o, 1'b0);
    repeat (SEQ_LEN) begin
      next_cycle();
      expect_sequential();
    end
  endtask

  task automatic stall_hold();
    int len;
    repeat (STALL_ROUNDS) begin
      len = int'(random_bits(3)) + 1;
      save_outputs();
      stall_i = 1'b1;
      repeat (len) begin
        next_cycle();
        check_held();
      end
      // Release continues the sequence where it stopped
      stall_i = 1'b0;
      next_cycle();
      expect_sequential();
    end
  endtask

  task automatic redirect_flow();
    pc_t tgt;
    repeat (REDIR_ROUNDS) begin
      tgt              = random_target();
      redirect_valid_i = 1'b1;
      redirect_tgt_i   = tgt;
      next_cycle();
      clear_inputs();
      expect_redirect(tgt);
      next_cycle();
      expect_sequential();
    end
  endtask

  task automatic prediction_flow();
    pc_t s_tgt;
    pc_t b_tgt;
    pc_t r_tgt;
    // Static prediction, same handoff as a redirect
    s_tgt               = random_target();
    static_pred_valid_i = 1'b1;
    static_pred_tgt_i   = s_tgt;
    next_cycle();
    clear_inputs();
    expect_redirect(s_tgt);
    next_cycle();
    expect_sequential();
    // Jump to a quiet region, train a branch four words ahead
    b_tgt            = random_target();
    redirect_valid_i = 1'b1;
    redirect_tgt_i   = BTB_REGION;
    btb_upd_valid_i  = 1'b1;
    btb_upd_pc_i     = BTB_REGION + 32'd16;
    btb_upd_tgt_i    = b_tgt;
    next_cycle();
    clear_inputs();
    expect_redirect(BTB_REGION);
    repeat (4) begin
      next_cycle();
      expect_sequential();
    end
    // Early hit steers fetch without a flush
    next_cycle();
    check_bit("fetch_valid_o", fetch_valid_o, 1'b1);
    check_pc("fetch_pc_o", fetch_pc_o, BTB_REGION + 32'd16);
    check_bit("fetch_btb_hit_o", fetch_btb_hit_o, 1'b1);
    check_pc("fetch_btb_tgt_o", fetch_btb_tgt_o, b_tgt);
    check_pc("fetch_pc_next_o", fetch_pc_next_o, b_tgt);
    check_bit("fetch_redir_pending_o", fetch_redir_pending_o, 1'b0);
    exp_pc = b_tgt;
    next_cycle();
    expect_sequential();
    // Redirect beats a static prediction in the same cycle
    r_tgt               = random_target();
    s_tgt               = random_target();
    redirect_valid_i    = 1'b1;
    redirect_tgt_i      = r_tgt;
    static_pred_valid_i = 1'b1;
    static_pred_tgt_i   = s_tgt;
    next_cycle();
    clear_inputs();
    expect_redirect(r_tgt);
    next_cycle();
    expect_sequential();
  endtask

  task automatic imem_stall_redirect();
    pc_t  tgt;
    pc_t  last_pc;
    logic reached;
    int   waited;
    tgt     = random_target();
    last_pc = fetch_pc_o;
    reached = 1'b0;
    waited  = 0;
    save_outputs();
    imem_stall_i = 1'b1;
    next_cycle();
    check_held();
    // Redirect lasts one cycle inside the memory stall
    redirect_valid_i = 1'b1;
    redirect_tgt_i   = tgt;
    next_cycle();
    check_held();
    clear_inputs();
    repeat (int'(random_bits(2)) + 1) begin
      next_cycle();
      check_held();
    end
    imem_stall_i = 1'b0;
    // Release edge is a bubble
    // Held target is already the next PC
    next_cycle();
    check_bit("fetch_valid_o", fetch_valid_o, 1'b0);
    check_pc("fetch_pc_next_o", fetch_pc_next_o, tgt);
    // Duplicate fetch address is never allowed
    while (!reached && waited < 4) begin
      next_cycle();
      waited++;
      if (fetch_valid_o) begin
        if (fetch_pc_o == last_pc) begin
          abort_run($sformatf("Two valid handoffs in a row fetch 0x%h", fetch_pc_o));
        end
        last_pc = fetch_pc_o;
        reached = (fetch_pc_o == tgt);
      end
    end
    if (!reached) begin
      abort_run("Fetch never reached the redirect target after the memory stall");
    end
    check_pc("fetch_pc_next_o", fetch_pc_next_o, tgt + 32'd4);
    exp_pc = tgt + 32'd4;
    next_cycle();
    expect_sequential();
  endtask

  initial begin
    lfsr_state   = 32'h24de;
    rst_n        = 1'b0;
    stall_i      = 1'b0;
    imem_stall_i = 1'b0;
    clear_inputs();
    exp_pc = `RV_FE_RESET_PC;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    sequential_flow();
    stall_hold();
    redirect_flow();
    prediction_flow();
    imem_stall_redirect();
    if (fe_top_inst.fe_sva_inst.fail_count != 0) begin
      abort_run("An assertion on the fetch handoff failed");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== dv/fe_sva.sv ====
`timescale 1ns/1ns

module fe_sva import rv_fe_pkg::*; (
  input logic clk,
  input logic rst_n,
  input logic stall_i,
  input logic imem_stall_i,
  input logic fetch_valid_o,
  input pc_t  fetch_pc_o,
  input pc_t  fetch_pc_next_o,
  input logic fetch_btb_hit_o,
  input pc_t  fetch_btb_tgt_o,
  input logic fetch_redir_pending_o
);

  // Failed assertions, watched by the testbench
  int unsigned fail_count = 0;

  logic stall;

  assign stall = stall_i | imem_stall_i;

  // Every handoff field holds across a stalled edge
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> $stable({fetch_valid_o, fetch_pc_o, fetch_pc_next_o,
                       fetch_btb_hit_o, fetch_btb_tgt_o, fetch_redir_pending_o}))
    else begin
      $error("Fetch handoff changed during a stall");
      fail_count++;
    end

  // New fetch address is the one announced by the previous handoff
  pc_chain: assert property (@(posedge clk) disable iff (!rst_n)
    (rst_n && !stall) ##1 fetch_valid_o |-> fetch_pc_o == $past(fetch_pc_next_o))
    else begin
      $error("fetch_pc_o does not follow the previous fetch_pc_next_o");
      fail_count++;
    end

  // No fetch right out of reset
  idle_after_reset: assert property (@(posedge clk) !rst_n |=> !fetch_valid_o)
    else begin
      $error("fetch_valid_o high in the cycle after reset");
      fail_count++;
    end

endmodule

bind fe_top fe_sva fe_sva_inst (
  .clk                   (clk),
  .rst_n                 (rst_n),
  .stall_i               (stall_i),
  .imem_stall_i          (imem_stall_i),
  .fetch_valid_o         (fetch_valid_o),
  .fetch_pc_o            (fetch_pc_o),
  .fetch_pc_next_o       (fetch_pc_next_o),
  .fetch_btb_hit_o       (fetch_btb_hit_o),
  .fetch_btb_tgt_o       (fetch_btb_tgt_o),
  .fetch_redir_pending_o (fetch_redir_pending_o)
);

// ==== hw/fe_top.sv ====
`timescale 1ns/1ns

module fe_top import rv_fe_pkg::*; (
  input  logic clk,
  input  logic rst_n,

  // Back-end redirect
  input  logic redirect_valid_i,
  input  pc_t  redirect_tgt_i,

  // Static prediction from decode
  input  logic static_pred_valid_i,
  input  pc_t  static_pred_tgt_i,

  // BTB training
  input  logic btb_upd_valid_i,
  input  pc_t  btb_upd_pc_i,
  input  pc_t  btb_upd_tgt_i,

  // Hazard stall and memory stall
  input  logic stall_i,
  input  logic imem_stall_i,

  // Fetch request to IF
  output logic fetch_valid_o,
  output pc_t  fetch_pc_o,
  output pc_t  fetch_pc_next_o,
  output logic fetch_btb_hit_o,
  output pc_t  fetch_btb_tgt_o,
  output logic fetch_redir_pending_o
);

  // Current PC feeds the BTB lookup
  pc_t  cur_pc;
  logic btb_hit;
  pc_t  btb_tgt;

  pc_sel_if    sel_if ();
  fetch_req_if fetch_if ();

  btb btb_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookup_pc_i (cur_pc),
    .hit_o       (btb_hit),
    .tgt_o       (btb_tgt),
    .upd_valid_i (btb_upd_valid_i),
    .upd_pc_i    (btb_upd_pc_i),
    .upd_tgt_i   (btb_upd_tgt_i)
  );

  pc_sel_arbiter pc_sel_arbiter_inst (
    .redirect_valid_i    (redirect_valid_i),
    .redirect_tgt_i      (redirect_tgt_i),
    .static_pred_valid_i (static_pred_valid_i),
    .static_pred_tgt_i   (static_pred_tgt_i),
    .btb_hit_i           (btb_hit),
    .btb_tgt_i           (btb_tgt),
    .sel                 (sel_if.arb)
  );

  // Lookup result also rides along as handoff metadata
  stage_pc stage_pc_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .sel          (sel_if.stage),
    .stall_i      (stall_i),
    .imem_stall_i (imem_stall_i),
    .btb_hit_i    (btb_hit),
    .btb_tgt_i    (btb_tgt),
    .pc_o         (cur_pc),
    .fetch        (fetch_if.stage)
  );

  // Handoff broken out to plain ports
  assign fetch_valid_o         = fetch_if.valid;
  assign fetch_pc_o            = fetch_if.pc;
  assign fetch_pc_next_o       = fetch_if.pc_next;
  assign fetch_btb_hit_o       = fetch_if.btb_hit;
  assign fetch_btb_tgt_o       = fetch_if.btb_tgt;
  assign fetch_redir_pending_o = fetch_if.redir_pending;

endmodule

// ==== stage_pc/stage_pc.sv ====
`timescale 1ns/1ns

`include "rv_fe_settings.svh"

module stage_pc import rv_fe_pkg::*; (
  input  logic clk,
  input  logic rst_n,

  // Next-PC decision from the arbiter
  pc_sel_if.stage sel,

  // Back-end stall and instruction memory stall
  input  logic stall_i,
  input  logic imem_stall_i,

  // BTB result for the current PC
  input  logic btb_hit_i,
  input  pc_t  btb_tgt_i,

  // Current PC register for the BTB lookup
  output pc_t  pc_o,

  // Registered handoff to IF
  fetch_req_if.stage fetch
);

  logic stall;
  logic advance;
  logic bubble;
  logic stale;
  logic was_stalled_q;

  pc_t  pc_q;
  pc_t  pc_next;

  logic redir_capture;
  logic pred_capture;
  logic redir_hold_q;
  pc_t  redir_hold_tgt_q;
  logic pred_hold_q;
  pc_t  pred_hold_tgt_q;

  logic redir_pending_next;

  logic valid_q;
  pc_t  fetch_pc_q;
  pc_t  fetch_pc_next_q;
  logic btb_hit_q;
  pc_t  btb_tgt_q;
  logic redir_pending_q;

  // Either stall source freezes the whole stage
  assign stall = stall_i | imem_stall_i;

  // A target seen during a memory stall must survive until fetch resumes
  assign redir_capture = (sel.sel == PC_SEL_REDIRECT) && imem_stall_i;
  assign pred_capture  = (sel.sel == PC_SEL_PREDICTED) && imem_stall_i;

  // Redirect hold
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      redir_hold_q <= 1'b0;
    end else if (redir_capture) begin
      redir_hold_q <= 1'b1;
    end else if (redir_hold_q && !stall) begin
      // Released on the edge that finally loads the target
      redir_hold_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (redir_capture) begin
      redir_hold_tgt_q <= sel.redir_tgt;
    end
  end

  // Prediction hold
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_hold_q <= 1'b0;
    end else if (sel.sel == PC_SEL_REDIRECT) begin
      // A redirect makes any pending prediction moot
      pred_hold_q <= 1'b0;
    end else if (pred_capture) begin
      pred_hold_q <= 1'b1;
    end else if (pred_hold_q && !stall) begin
      pred_hold_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pred_capture) begin
      pred_hold_tgt_q <= sel.pred_tgt;
    end
  end

  // Next PC
  // Held redirect first, then live redirect, held prediction, live prediction
  always_comb begin
    if (redir_hold_q) begin
      pc_next = redir_hold_tgt_q;
    end else if (sel.sel == PC_SEL_REDIRECT) begin
      pc_next = sel.redir_tgt;
    end else if (pred_hold_q) begin
      pc_next = pred_hold_tgt_q;
    end else if (sel.sel == PC_SEL_PREDICTED) begin
      pc_next = sel.pred_tgt;
    end else begin
      pc_next = pc_q + pc_t'(4);
    end
  end

  // PC register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= `RV_FE_RESET_PC;
    end else if (!stall) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // Stall release with a redirect still held
  // Next fetch address would repeat, so this edge is a bubble
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      was_stalled_q <= 1'b0;
    end else begin
      was_stalled_q <= stall;
    end
  end

  assign stale   = was_stalled_q && !stall && redir_hold_q;
  assign advance = !stall && !stale;
  assign bubble  = !stall && stale;

  // Only redirects and late predictions need the extended flush
  assign redir_pending_next = (sel.sel == PC_SEL_REDIRECT) ||
                              ((sel.sel == PC_SEL_PREDICTED) && !sel.pred_early);

  // Valid to IF
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= 1'b1;
    end else if (bubble) begin
      valid_q <= 1'b0;
    end
  end

  // Handoff data moves on a bubble too, so pc_next is right when valid returns
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_pc_q      <= `RV_FE_RESET_PC;
      fetch_pc_next_q <= `RV_FE_RESET_PC;
      btb_hit_q       <= 1'b0;
      btb_tgt_q       <= '0;
      redir_pending_q <= 1'b0;
    end else if (advance || bubble) begin
      fetch_pc_q      <= pc_q;
      fetch_pc_next_q <= pc_next;
      btb_hit_q       <= btb_hit_i;
      btb_tgt_q       <= btb_tgt_i;
      redir_pending_q <= redir_pending_next;
    end
  end

  assign fetch.valid         = valid_q;
  assign fetch.pc            = fetch_pc_q;
  assign fetch.pc_next       = fetch_pc_next_q;
  assign fetch.btb_hit       = btb_hit_q;
  assign fetch.btb_tgt       = btb_tgt_q;
  assign fetch.redir_pending = redir_pending_q;

endmodule

// ==== hw/pc_sel_arbiter.sv ====
`timescale 1ns/1ns

module pc_sel_arbiter import rv_fe_pkg::*; (
  // Misprediction or jump resolved in the back end
  input  logic redirect_valid_i,
  input  pc_t  redirect_tgt_i,

  // Late static prediction from decode
  input  logic static_pred_valid_i,
  input  pc_t  static_pred_tgt_i,

  // Early prediction from the BTB lookup
  input  logic btb_hit_i,
  input  pc_t  btb_tgt_i,

  // Decision to the PC stage
  pc_sel_if.arb sel
);

  // Redirect target goes through untouched
  assign sel.redir_tgt = redirect_tgt_i;

  // Priority is redirect, then static prediction, then BTB hit
  always_comb begin
    sel.sel        = PC_SEL_SEQUENTIAL;
    sel.pred_early = 1'b0;
    // Static predictor owns the target whenever it fires
    sel.pred_tgt   = static_pred_valid_i ? static_pred_tgt_i : btb_tgt_i;

    if (redirect_valid_i) begin
      sel.sel = PC_SEL_REDIRECT;
    end else if (static_pred_valid_i) begin
      // Sequential path already fetched, needs a flush downstream
      sel.sel = PC_SEL_PREDICTED;
    end else if (btb_hit_i) begin
      // Caught in fetch so nothing wrong was issued
      sel.sel        = PC_SEL_PREDICTED;
      sel.pred_early = 1'b1;
    end
  end

endmodule

// ==== hw/btb.sv ====
`timescale 1ns/1ns

`include "rv_fe_settings.svh"

module btb import rv_fe_pkg::*; (
  input  logic clk,
  input  logic rst_n,

  // Lookup on the current PC register
  input  pc_t  lookup_pc_i,
  output logic hit_o,
  output pc_t  tgt_o,

  // Training port from the back end
  input  logic upd_valid_i,
  input  pc_t  upd_pc_i,
  input  pc_t  upd_tgt_i
);

  localparam int ENTRIES = `RV_FE_BTB_ENTRIES;

  // One valid bit per entry
  logic [ENTRIES-1:0] valid_q;

  // Tag and target storage
  btb_tag_t tag_q [ENTRIES];
  pc_t      tgt_q [ENTRIES];

  btb_idx_t lookup_idx;
  btb_tag_t lookup_tag;
  btb_idx_t upd_idx;
  btb_tag_t upd_tag;

  // Drop the byte offset, then split into index and tag
  assign lookup_idx = btb_idx_t'(lookup_pc_i >> 2);
  assign lookup_tag = btb_tag_t'(lookup_pc_i >> (BTB_IDX_W + 2));
  assign upd_idx    = btb_idx_t'(upd_pc_i >> 2);
  assign upd_tag    = btb_tag_t'(upd_pc_i >> (BTB_IDX_W + 2));

  // Valid bits
  // An update marks its entry, reset empties the table
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Entry contents
  // A new branch at the same index evicts the old one
  always_ff @(posedge clk) begin
    if (upd_valid_i) begin
      tag_q[upd_idx] <= upd_tag;
      tgt_q[upd_idx] <= upd_tgt_i;
    end
  end

  // Combinational lookup
  // Every stored entry is treated as taken
  // Written entries show up one cycle after the update edge
  assign hit_o = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign tgt_o = tgt_q[lookup_idx];

endmodule

// ==== common/rv_fe_intf.sv ====
`timescale 1ns/1ns

// Next-PC decision from the arbiter to the PC stage
// No handshake, the stage samples it whenever it advances
interface pc_sel_if import rv_fe_pkg::*; ();

  pc_sel_e sel;
  pc_t     redir_tgt;
  pc_t     pred_tgt;
  // Prediction came from the BTB during fetch
  logic    pred_early;

  modport arb (
    output sel,
    output redir_tgt,
    output pred_tgt,
    output pred_early
  );

  modport stage (
    input sel,
    input redir_tgt,
    input pred_tgt,
    input pred_early
  );

endinterface

// Registered fetch request from the PC stage to the IF stage
// All fields hold while the stage is stalled
interface fetch_req_if import rv_fe_pkg::*; ();

  logic valid;
  pc_t  pc;
  pc_t  pc_next;
  logic btb_hit;
  pc_t  btb_tgt;
  logic redir_pending;

  modport stage (
    output valid,
    output pc,
    output pc_next,
    output btb_hit,
    output btb_tgt,
    output redir_pending
  );

  modport sink (
    input valid,
    input pc,
    input pc_next,
    input btb_hit,
    input btb_tgt,
    input redir_pending
  );

endinterface

// ==== common/rv_fe_pkg.sv ====
package rv_fe_pkg;

  `include "rv_fe_settings.svh"

  // Index bits sit just above the byte offset of a word
  localparam int BTB_IDX_W = $clog2(`RV_FE_BTB_ENTRIES);

  // Tag keeps every PC bit above the index
  localparam int BTB_TAG_W = `RV_FE_XLEN - BTB_IDX_W - 2;

  // Program counter or branch target
  typedef logic [`RV_FE_XLEN-1:0] pc_t;

  // Entry select into the BTB table
  typedef logic [BTB_IDX_W-1:0] btb_idx_t;

  // Upper PC bits stored with each entry
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // Source of the next fetch address
  // Redirect wins over prediction, prediction wins over PC + 4
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'b00,
    PC_SEL_PREDICTED  = 2'b01,
    PC_SEL_REDIRECT   = 2'b10
  } pc_sel_e;

endpackage

// ==== common/rv_fe_settings.svh ====
`ifndef RV_FE_SETTINGS_SVH
`define RV_FE_SETTINGS_SVH

// Width of a PC or a branch target
`define RV_FE_XLEN 32

// First fetch address after reset
`define RV_FE_RESET_PC 32'h0000_1000

// Number of BTB entries
// Keep this a power of two
`define RV_FE_BTB_ENTRIES 16

`endif
